//--- nvram_map_pkg.sv
package nvram_map_pkg;

   localparam int NUM_SLOTS    = 4;              // Battery-backed regions
   localparam int SECTOR_BYTES = 512;
   localparam int SECTOR_AW    = 9;              // Byte offset inside a sector
   localparam int RAM_AW       = 27;             // System RAM byte address
   localparam int SD_BUFF_AW   = 14;             // Host side buffer address
   localparam int SLOT_KB_W    = 16;
   localparam int SECTOR_CNT_W = SLOT_KB_W + 1;  // Two sectors per KiB

   // One entry of the slot map supplied by the core
   typedef struct packed {
      logic [RAM_AW-1:0]    base_addr;  // First byte of the slot in RAM
      logic [SLOT_KB_W-1:0] size_kb;    // Zero marks an unused slot
   } slot_map_t;

   // Host write into the sector buffer
   typedef struct packed {
      logic                  wr;
      logic [SD_BUFF_AW-1:0] addr;     // Only the low SECTOR_AW bits select a byte
      logic [7:0]            data;
   } sd_buff_wr_t;

   // Byte-wide system RAM command
   typedef struct packed {
      logic              req;          // One-cycle pulse
      logic              rnw;          // 1 read, 0 write
      logic [RAM_AW-1:0] addr;
      logic [7:0]        din;
   } ram_cmd_t;

endpackage

//--- nvram_ctrl_pkg.sv
package nvram_ctrl_pkg;

   typedef logic [1:0] slot_idx_t;  // One of four slots

   typedef enum logic {
      DIR_SAVE,                     // RAM to SD image
      DIR_LOAD                      // SD image to RAM
   } xfer_dir_t;

   typedef enum logic [1:0] {
      ST_SLEEP,                     // Waiting for start
      ST_BUFF_FILL,                 // RAM bytes into buffer
      ST_SD_IO,                     // Sector read or write on SD
      ST_RAM_WRITE                  // Buffer bytes into RAM
   } seq_state_t;

endpackage

//--- sector_buffer.sv
module sector_buffer import nvram_map_pkg::*; (
   input  logic                 clk,
   input  sd_buff_wr_t          host_wr,
   output logic [7:0]           host_q,
   input  logic [SECTOR_AW-1:0] addr_b,
   input  logic                 we_b,
   input  logic [7:0]           data_b,
   output logic [7:0]           q_b
);

   logic [7:0]           mem [SECTOR_BYTES];
   logic [SECTOR_AW-1:0] addr_a;

   assign addr_a = host_wr.addr[SECTOR_AW-1:0];  // Host address wraps per sector

   always_ff @(posedge clk) begin
      if (host_wr.wr) begin
         mem[addr_a] <= host_wr.data;
      end
      if (we_b) begin
         mem[addr_b] <= data_b;
      end
      host_q <= mem[addr_a];  // Registered with one cycle latency
      q_b    <= mem[addr_b];
   end

endmodule

//--- nvram_image_table.sv
module nvram_image_table import nvram_map_pkg::*; import nvram_ctrl_pkg::*; (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic [NUM_SLOTS-1:0] img_mounted,
   input  logic                 img_readonly,
   input  logic [31:0]          img_size,
   input  logic                 size_update,
   input  slot_idx_t            update_slot,
   input  logic [SLOT_KB_W-1:0] update_kb,
   output logic [NUM_SLOTS-1:0] writable,
   output logic [NUM_SLOTS-1:0] has_image
);

   logic [31:0] image_bytes [NUM_SLOTS];  // Image size in bytes

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         writable <= '0;
         for (int i = 0; i < NUM_SLOTS; i++) begin
            image_bytes[i] <= '0;
         end
      end else begin
         for (int i = 0; i < NUM_SLOTS; i++) begin
            if (img_mounted[i]) begin
               writable[i]    <= ~img_readonly;  // Mounted and not read-only
               image_bytes[i] <= img_size;
            end
         end
         if (size_update) begin
            image_bytes[update_slot] <= 32'(update_kb) << 10;  // Image now holds the slot
         end
      end
   end

   always_comb begin
      for (int i = 0; i < NUM_SLOTS; i++) begin
         has_image[i] = |image_bytes[i];
      end
   end

   // The host mounts one image at a time, so the shared size bus is unambiguous
   a_single_mount: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(img_mounted));

endmodule

//--- nvram_slot_arbiter.sv
module nvram_slot_arbiter import nvram_map_pkg::*; import nvram_ctrl_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  logic      load_req,
   input  logic      save_req,
   input  logic      done,
   output logic      start,
   output xfer_dir_t dir,
   output slot_idx_t active_slot
);

   logic                 last_load;
   logic                 last_save;
   logic [NUM_SLOTS-1:0] pend_load;
   logic [NUM_SLOTS-1:0] pend_save;
   logic                 busy;       // Sequencer owns active_slot

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         last_load   <= 1'b0;
         last_save   <= 1'b0;
         pend_load   <= '0;
         pend_save   <= '0;
         busy        <= 1'b0;
         start       <= 1'b0;
         dir         <= DIR_SAVE;
         active_slot <= '0;
      end else begin
         last_load <= load_req;
         last_save <= save_req;
         start     <= 1'b0;

         if (done) begin
            busy <= 1'b0;
            if (dir == DIR_SAVE) begin
               pend_save[active_slot] <= 1'b0;
            end else begin
               pend_load[active_slot] <= 1'b0;
            end
         end

         // A new edge marks every slot again
         if (load_req && !last_load) begin
            pend_load <= '1;
         end
         if (save_req && !last_save) begin
            pend_save <= '1;
         end

         if (!busy) begin
            if (pend_save[active_slot]) begin  // Save wins over load
               start <= 1'b1;
               dir   <= DIR_SAVE;
               busy  <= 1'b1;
            end else if (pend_load[active_slot]) begin
               start <= 1'b1;
               dir   <= DIR_LOAD;
               busy  <= 1'b1;
            end else begin
               active_slot <= slot_idx_t'(active_slot + 1'b1);  // Round-robin
            end
         end
      end
   end

endmodule

//--- nvram_sequencer.sv
module nvram_sequencer import nvram_map_pkg::*; import nvram_ctrl_pkg::*; (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 start,
   input  xfer_dir_t            dir,
   input  slot_idx_t            slot,
   input  slot_map_t            slot_map [NUM_SLOTS],
   input  logic [NUM_SLOTS-1:0] writable,
   input  logic [NUM_SLOTS-1:0] has_image,
   output logic                 done,
   output logic                 size_update,
   output logic [SLOT_KB_W-1:0] update_kb,
   output logic [31:0]          sd_lba,
   output logic [NUM_SLOTS-1:0] sd_rd,
   output logic [NUM_SLOTS-1:0] sd_wr,
   input  logic [NUM_SLOTS-1:0] sd_ack,
   output ram_cmd_t             ram_cmd,
   input  logic                 ram_ready,
   input  logic [7:0]           ram_dout,
   output logic [SECTOR_AW-1:0] buf_addr,
   output logic                 buf_we,
   input  logic [7:0]           buf_q
);

   seq_state_t              state;
   xfer_dir_t               cur_dir;
   slot_idx_t               cur_slot;
   logic [SECTOR_CNT_W-1:0] sector;       // Also the image LBA
   logic [SECTOR_CNT_W-1:0] last_sector;
   logic [SECTOR_AW-1:0]    ofs;          // Byte inside the sector
   logic                    ram_req;
   logic                    ram_rnw;
   logic                    ram_busy;     // Access issued and waiting for ready
   logic                    buf_valid;    // buf_q belongs to ofs
   logic                    last_ack;
   logic                    eligible;
   logic                    ack_fall;

   assign eligible = (slot_map[slot].size_kb != '0) && writable[slot] &&
                     (dir == DIR_SAVE || has_image[slot]);
   assign ack_fall  = last_ack && !sd_ack[cur_slot];  // Host finished the sector
   assign sd_lba    = 32'(sector);
   assign buf_addr  = ofs;
   assign update_kb = slot_map[cur_slot].size_kb;

   // Read data is valid once ready returns after the request cycle
   assign buf_we = (state == ST_BUFF_FILL) && ram_busy && ram_ready && !ram_req;

   always_comb begin
      ram_cmd.req  = ram_req;
      ram_cmd.rnw  = ram_rnw;
      ram_cmd.addr = slot_map[cur_slot].base_addr + RAM_AW'({sector, ofs});
      ram_cmd.din  = buf_q;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state       <= ST_SLEEP;
         cur_dir     <= DIR_SAVE;
         cur_slot    <= '0;
         sector      <= '0;
         ram_req     <= 1'b0;
         ram_rnw     <= 1'b1;
         ram_busy    <= 1'b0;
         buf_valid   <= 1'b0;
         last_ack    <= 1'b0;
         sd_rd       <= '0;
         sd_wr       <= '0;
         done        <= 1'b0;
         size_update <= 1'b0;
      end else begin
         done        <= 1'b0;
         size_update <= 1'b0;
         last_ack    <= sd_ack[cur_slot];

         if (ram_req) begin
            ram_req <= 1'b0;  // RAM drops ready after this cycle
         end else begin
            case (state)
               ST_SLEEP: begin
                  if (start) begin
                     cur_dir  <= dir;
                     cur_slot <= slot;
                     sector   <= '0;
                     ofs      <= '0;
                     ram_busy <= 1'b0;
                     if (eligible) begin
                        last_sector <= {slot_map[slot].size_kb - 1'b1, 1'b1};  // 2N-1
                        if (dir == DIR_SAVE) begin
                           state <= ST_BUFF_FILL;
                        end else begin
                           sd_rd[slot] <= 1'b1;
                           state       <= ST_SD_IO;
                        end
                     end else begin
                        done <= 1'b1;  // Skipped slot
                     end
                  end
               end

               ST_BUFF_FILL: begin
                  if (!ram_busy) begin
                     if (ram_ready) begin
                        ram_req  <= 1'b1;
                        ram_rnw  <= 1'b1;
                        ram_busy <= 1'b1;
                     end
                  end else if (ram_ready) begin
                     ram_busy <= 1'b0;
                     ofs      <= ofs + 1'b1;  // Wraps to 0 at sector end
                     if (ofs == '1) begin
                        sd_wr[cur_slot] <= 1'b1;
                        state           <= ST_SD_IO;
                     end
                  end
               end

               ST_SD_IO: begin
                  if (ack_fall) begin
                     sd_rd <= '0;
                     sd_wr <= '0;
                     if (cur_dir == DIR_LOAD) begin
                        ofs       <= '0;
                        buf_valid <= 1'b0;
                        ram_busy  <= 1'b0;
                        state     <= ST_RAM_WRITE;
                     end else if (sector == last_sector) begin
                        done        <= 1'b1;
                        size_update <= 1'b1;
                        state       <= ST_SLEEP;
                     end else begin
                        sector <= sector + 1'b1;
                        state  <= ST_BUFF_FILL;
                     end
                  end
               end

               ST_RAM_WRITE: begin
                  if (!ram_busy) begin
                     if (buf_valid && ram_ready) begin
                        ram_req  <= 1'b1;
                        ram_rnw  <= 1'b0;
                        ram_busy <= 1'b1;
                     end
                     buf_valid <= 1'b1;  // Buffer read latency covered
                  end else if (ram_ready) begin
                     ram_busy  <= 1'b0;
                     buf_valid <= 1'b0;
                     ofs       <= ofs + 1'b1;
                     if (ofs == '1) begin
                        if (sector == last_sector) begin
                           done  <= 1'b1;
                           state <= ST_SLEEP;
                        end else begin
                           sector          <= sector + 1'b1;
                           sd_rd[cur_slot] <= 1'b1;
                           state           <= ST_SD_IO;
                        end
                     end
                  end
               end

               default: state <= ST_SLEEP;
            endcase
         end
      end
   end

   a_one_sd_dir: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0({sd_rd, sd_wr}));

   // RAM must be idle when a new access starts
   a_req_ready: assert property (@(posedge clk) disable iff (!rst_n)
      ram_cmd.req |-> ram_ready);

   // Returned read data must be defined when it lands in the buffer
   a_dout_known: assert property (@(posedge clk) disable iff (!rst_n)
      buf_we |-> !$isunknown(ram_dout));

endmodule

//--- nvram_backup_top.sv
module nvram_backup_top import nvram_map_pkg::*; import nvram_ctrl_pkg::*; (
   input  logic                 clk,
   input  logic                 rst_n,
   input  slot_map_t            slot_map [NUM_SLOTS],
   input  logic                 load_req,
   input  logic                 save_req,
   input  logic [NUM_SLOTS-1:0] img_mounted,
   input  logic                 img_readonly,
   input  logic [31:0]          img_size,
   output logic [31:0]          sd_lba,
   output logic [NUM_SLOTS-1:0] sd_rd,
   output logic [NUM_SLOTS-1:0] sd_wr,
   input  logic [NUM_SLOTS-1:0] sd_ack,
   input  sd_buff_wr_t          sd_buff_in,
   output logic [7:0]           sd_buff_din,
   output ram_cmd_t             ram_cmd,
   input  logic                 ram_ready,
   input  logic [7:0]           ram_dout
);

   slot_idx_t            active_slot;
   xfer_dir_t            dir;
   logic                 start;
   logic                 done;
   logic                 size_update;
   logic [SLOT_KB_W-1:0] update_kb;
   logic [NUM_SLOTS-1:0] writable;
   logic [NUM_SLOTS-1:0] has_image;
   logic [SECTOR_AW-1:0] buf_addr;
   logic                 buf_we;
   logic [7:0]           buf_q;

   nvram_slot_arbiter u_arbiter (
      .clk         (clk),
      .rst_n       (rst_n),
      .load_req    (load_req),
      .save_req    (save_req),
      .done        (done),
      .start       (start),
      .dir         (dir),
      .active_slot (active_slot)
   );

   nvram_image_table u_table (
      .clk          (clk),
      .rst_n        (rst_n),
      .img_mounted  (img_mounted),
      .img_readonly (img_readonly),
      .img_size     (img_size),
      .size_update  (size_update),
      .update_slot  (active_slot),  // Held by the arbiter until done
      .update_kb    (update_kb),
      .writable     (writable),
      .has_image    (has_image)
   );

   nvram_sequencer u_sequencer (
      .clk         (clk),
      .rst_n       (rst_n),
      .start       (start),
      .dir         (dir),
      .slot        (active_slot),
      .slot_map    (slot_map),
      .writable    (writable),
      .has_image   (has_image),
      .done        (done),
      .size_update (size_update),
      .update_kb   (update_kb),
      .sd_lba      (sd_lba),
      .sd_rd       (sd_rd),
      .sd_wr       (sd_wr),
      .sd_ack      (sd_ack),
      .ram_cmd     (ram_cmd),
      .ram_ready   (ram_ready),
      .ram_dout    (ram_dout),
      .buf_addr    (buf_addr),
      .buf_we      (buf_we),
      .buf_q       (buf_q)
   );

   sector_buffer u_buffer (
      .clk     (clk),
      .host_wr (sd_buff_in),
      .host_q  (sd_buff_din),
      .addr_b  (buf_addr),
      .we_b    (buf_we),
      .data_b  (ram_dout),      // Save path fills straight from RAM
      .q_b     (buf_q)
   );

endmodule

//--- tb_nvram_models.sv
module sd_host_model import nvram_map_pkg::*; (
   input  logic                 clk,
   input  logic [31:0]          sd_lba,
   input  logic [NUM_SLOTS-1:0] sd_rd,
   input  logic [NUM_SLOTS-1:0] sd_wr,
   output logic [NUM_SLOTS-1:0] sd_ack,
   output sd_buff_wr_t          sd_buff_in,
   input  logic [7:0]           sd_buff_din
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam int IMAGE_BYTES = 1024;  // One KiB image per slot

   logic [7:0]  image [NUM_SLOTS][IMAGE_BYTES];
   logic [31:0] bytes_written [NUM_SLOTS];
   logic [31:0] wr_lba_log [$];        // LBA of every sector write, in order

   // Port A output lags the address by two edges here
   task automatic save_sector(input int s, input int lba);
      int first;
      int idx;
      first = lba * SECTOR_BYTES;
      sd_ack[s] <= 1'b1;
      for (int i = 0; i < SECTOR_BYTES + 2; i++) begin
         if (i < SECTOR_BYTES) begin
            sd_buff_in.addr <= SD_BUFF_AW'(i);
         end
         idx = first + i - 2;
         if (i >= 2 && idx < IMAGE_BYTES) begin
            image[s][idx] = sd_buff_din;
         end
         @(posedge clk);
      end
      sd_ack[s]        <= 1'b0;  // Falling ack ends the sector
      bytes_written[s] = bytes_written[s] + 32'(SECTOR_BYTES);
      wr_lba_log.push_back(32'(lba));
      while (sd_wr[s]) begin
         @(posedge clk);
      end
   endtask

   task automatic load_sector(input int s, input int lba);
      int first;
      first = lba * SECTOR_BYTES;
      sd_ack[s] <= 1'b1;
      for (int i = 0; i < SECTOR_BYTES; i++) begin
         sd_buff_in.wr   <= 1'b1;
         sd_buff_in.addr <= SD_BUFF_AW'(i);
         sd_buff_in.data <= (first + i < IMAGE_BYTES) ? image[s][first + i] : 8'h00;
         @(posedge clk);
      end
      sd_buff_in.wr <= 1'b0;
      sd_ack[s]     <= 1'b0;
      while (sd_rd[s]) begin
         @(posedge clk);
      end
   endtask

   initial begin
      sd_ack     <= '0;
      sd_buff_in <= '0;
      for (int s = 0; s < NUM_SLOTS; s++) begin
         bytes_written[s] = '0;
      end
      forever begin
         @(posedge clk);
         for (int s = 0; s < NUM_SLOTS; s++) begin
            if (sd_wr[s] === 1'b1) begin
               save_sector(s, int'(sd_lba));
            end else if (sd_rd[s] === 1'b1) begin
               load_sector(s, int'(sd_lba));
            end
         end
      end
   end

endmodule

module ram_model import nvram_map_pkg::*; (
   input  logic       clk,
   input  ram_cmd_t   ram_cmd,
   output logic       ram_ready,
   output logic [7:0] ram_dout
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam int          MEM_AW    = 14;  // Four slots 4 KiB apart
   localparam logic [31:0] RAND_SEED = 32'hc198_3634;

   logic [7:0]  mem [2**MEM_AW];
   int unsigned max_delay = 2;               // Most extra busy cycles per access

   initial begin
      ram_cmd_t    cmd;
      int unsigned busy_cycles;
      void'($urandom(RAND_SEED));
      ram_ready <= 1'b1;
      ram_dout  <= '0;
      forever begin
         @(posedge clk);
         if (ram_cmd.req === 1'b1) begin
            cmd         = ram_cmd;
            busy_cycles = $urandom % (max_delay + 1);
            ram_ready <= 1'b0;
            repeat (busy_cycles) begin
               @(posedge clk);
            end
            @(posedge clk);
            if (cmd.rnw) begin
               ram_dout <= mem[cmd.addr[MEM_AW-1:0]];  // Valid with ready
            end else begin
               mem[cmd.addr[MEM_AW-1:0]] = cmd.din;
            end
            ram_ready <= 1'b1;
         end
      end
   end

endmodule

//--- tb_nvram_backup.sv
module tb_nvram_backup import nvram_map_pkg::*; ();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int SLOT_STRIDE       = 'h1000;  // RAM distance between slot bases
   localparam int SLOT_BYTES        = 1024;
   localparam int TOTAL_SECTORS     = 38;      // Sum over all tests below
   localparam int CYCLES_PER_SECTOR = 8192;    // 512 bytes at the worst RAM delay plus SD
   localparam int TIMEOUT_CYCLES    = TOTAL_SECTORS * CYCLES_PER_SECTOR;

   logic                 clk = 1'b0;
   logic                 rst_n;
   slot_map_t            slot_map [NUM_SLOTS];
   logic                 load_req;
   logic                 save_req;
   logic [NUM_SLOTS-1:0] img_mounted;
   logic                 img_readonly;
   logic [31:0]          img_size;
   logic [31:0]          sd_lba;
   logic [NUM_SLOTS-1:0] sd_rd;
   logic [NUM_SLOTS-1:0] sd_wr;
   logic [NUM_SLOTS-1:0] sd_ack;
   sd_buff_wr_t          sd_buff_in;
   logic [7:0]           sd_buff_din;
   ram_cmd_t             ram_cmd;
   logic                 ram_ready;
   logic [7:0]           ram_dout;
   int                   cycle_count = 0;

   nvram_backup_top UUT (
      .clk          (clk),
      .rst_n        (rst_n),
      .slot_map     (slot_map),
      .load_req     (load_req),
      .save_req     (save_req),
      .img_mounted  (img_mounted),
      .img_readonly (img_readonly),
      .img_size     (img_size),
      .sd_lba       (sd_lba),
      .sd_rd        (sd_rd),
      .sd_wr        (sd_wr),
      .sd_ack       (sd_ack),
      .sd_buff_in   (sd_buff_in),
      .sd_buff_din  (sd_buff_din),
      .ram_cmd      (ram_cmd),
      .ram_ready    (ram_ready),
      .ram_dout     (ram_dout)
   );

   sd_host_model host (
      .clk         (clk),
      .sd_lba      (sd_lba),
      .sd_rd       (sd_rd),
      .sd_wr       (sd_wr),
      .sd_ack      (sd_ack),
      .sd_buff_in  (sd_buff_in),
      .sd_buff_din (sd_buff_din)
   );

   ram_model ram (
      .clk       (clk),
      .ram_cmd   (ram_cmd),
      .ram_ready (ram_ready),
      .ram_dout  (ram_dout)
   );

   always #10 clk = ~clk;  // 20 ns period

   function automatic logic [7:0] ram_byte(input int addr, input logic [7:0] salt);
      return 8'(addr) ^ 8'(addr >> 8) ^ 8'(addr >> 16) ^ salt;
   endfunction

   function automatic logic [7:0] image_byte(input int slot, input int ofs,
                                             input logic [7:0] salt);
      return 8'(ofs * 7 + slot * 61) ^ 8'(ofs >> 8) ^ salt;
   endfunction

   task automatic stop_on_error(input string what);
      $display("%s", what);
      $display("Regression failed");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp) begin
         stop_on_error($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                                 $time, name, got, exp));
      end
   endtask

   task automatic check_size(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
      if (got !== exp) begin
         stop_on_error($sformatf("CHECK FAILED at %0t: %s is %0d, expected %0d",
                                 $time, name, got, exp));
      end
   endtask

   task automatic check_lba(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         stop_on_error($sformatf("CHECK FAILED at %0t: %s is %0d, expected %0d",
                                 $time, name, got, exp));
      end
   endtask

   task automatic fill_ram(input int slot, input logic [7:0] salt);
      int a;
      for (int i = 0; i < SLOT_BYTES; i++) begin
         a = slot * SLOT_STRIDE + i;
         ram.mem[a] = ram_byte(a, salt);
      end
   endtask

   task automatic clear_ram(input int slot);
      for (int i = 0; i < SLOT_BYTES; i++) begin
         ram.mem[slot * SLOT_STRIDE + i] = 8'h00;
      end
   endtask

   task automatic fill_image(input int slot, input logic [7:0] salt);
      for (int i = 0; i < SLOT_BYTES; i++) begin
         host.image[slot][i] = image_byte(slot, i, salt);
      end
   endtask

   // Expected RAM comes from the RAM pattern or from the image pattern
   task automatic check_ram(input int slot, input logic from_image, input logic [7:0] salt);
      int         a;
      logic [7:0] exp;
      for (int i = 0; i < SLOT_BYTES; i++) begin
         a   = slot * SLOT_STRIDE + i;
         exp = from_image ? image_byte(slot, i, salt) : ram_byte(a, salt);
         check_byte($sformatf("ram[%h]", a), ram.mem[a], exp);
      end
   endtask

   task automatic check_image(input int slot, input logic from_ram, input logic [7:0] salt);
      logic [7:0] exp;
      for (int i = 0; i < SLOT_BYTES; i++) begin
         exp = from_ram ? ram_byte(slot * SLOT_STRIDE + i, salt) : image_byte(slot, i, salt);
         check_byte($sformatf("image%0d[%0d]", slot, i), host.image[slot][i], exp);
      end
   endtask

   task automatic mount_image(input int slot, input logic readonly, input logic [31:0] size);
      @(posedge clk);
      img_mounted  <= NUM_SLOTS'(1) << slot;
      img_readonly <= readonly;
      img_size     <= size;
      @(posedge clk);
      img_mounted  <= '0;
   endtask

   task automatic pulse_req(input logic save, input logic load);
      @(posedge clk);
      save_req <= save;
      load_req <= load;
      @(posedge clk);
      save_req <= 1'b0;
      load_req <= 1'b0;
   endtask

   // Every request edge serves each slot once per direction
   task automatic wait_done(input int count);
      int seen;
      seen = 0;
      while (seen < count) begin
         @(posedge clk);
         if (UUT.done) begin
            seen++;
         end
      end
   endtask

   task automatic save_single_slot();
      fill_ram(0, 8'h11);
      fill_image(0, 8'h99);
      mount_image(0, 1'b0, 32'd0);
      pulse_req(1'b1, 1'b0);
      wait_done(NUM_SLOTS);
      check_size("bytes written to slot 0", host.bytes_written[0], 32'd1024);
      check_lba("first sector lba", host.wr_lba_log[0], 32'd0);
      check_lba("second sector lba", host.wr_lba_log[1], 32'd1);
      check_image(0, 1'b1, 8'h11);
   endtask

   task automatic load_into_slot();
      fill_image(1, 8'h22);
      mount_image(1, 1'b0, 32'd1024);
      clear_ram(1);
      pulse_req(1'b0, 1'b1);
      wait_done(NUM_SLOTS);
      check_ram(1, 1'b1, 8'h22);
      check_ram(0, 1'b0, 8'h11);  // Reloaded from its own saved image
   endtask

   task automatic skip_protected_slots();
      fill_image(2, 8'h33);
      fill_image(3, 8'h44);
      mount_image(2, 1'b1, 32'd1024);  // Read-only while slot 3 stays unmounted
      pulse_req(1'b1, 1'b0);
      wait_done(NUM_SLOTS);
      check_size("bytes written to slot 2", host.bytes_written[2], 32'd0);
      check_size("bytes written to slot 3", host.bytes_written[3], 32'd0);
      check_image(2, 1'b0, 8'h33);
      check_image(3, 1'b0, 8'h44);
   endtask

   task automatic empty_image_restore();
      fill_ram(3, 8'h55);
      fill_image(3, 8'h66);
      mount_image(3, 1'b0, 32'd0);
      pulse_req(1'b0, 1'b1);
      wait_done(NUM_SLOTS);
      check_ram(3, 1'b0, 8'h55);
      pulse_req(1'b1, 1'b0);
      wait_done(NUM_SLOTS);
      check_size("bytes written to slot 3", host.bytes_written[3], 32'd1024);
      clear_ram(3);
      pulse_req(1'b0, 1'b1);  // Image is no longer empty
      wait_done(NUM_SLOTS);
      check_ram(3, 1'b0, 8'h55);
   endtask

   task automatic save_then_load_same_edge();
      ram.max_delay = 6;  // Heavy ready back-pressure
      for (int s = 0; s < NUM_SLOTS; s++) begin
         fill_ram(s, 8'h77);
      end
      pulse_req(1'b1, 1'b1);
      wait_done(2 * NUM_SLOTS);
      for (int s = 0; s < NUM_SLOTS; s++) begin
         check_ram(s, 1'b0, 8'h77);
      end
   endtask

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         stop_on_error($sformatf("Timeout, tests did not finish in %0d cycles",
                                 TIMEOUT_CYCLES));
      end
   end

   initial begin
      rst_n        <= 1'b0;
      load_req     <= 1'b0;
      save_req     <= 1'b0;
      img_mounted  <= '0;
      img_readonly <= 1'b0;
      img_size     <= '0;
      for (int s = 0; s < NUM_SLOTS; s++) begin
         slot_map[s] <= '{base_addr: RAM_AW'(s * SLOT_STRIDE), size_kb: 16'd1};
      end
      repeat (4) begin
         @(posedge clk);
      end
      rst_n <= 1'b1;
      save_single_slot();
      load_into_slot();
      skip_protected_slots();
      empty_image_restore();
      save_then_load_same_edge();
      $display("Regression passed");
      $finish;
   end

endmodule

//--- filelist.f
nvram_map_pkg.sv
nvram_ctrl_pkg.sv
sector_buffer.sv
nvram_image_table.sv
nvram_slot_arbiter.sv
nvram_sequencer.sv
nvram_backup_top.sv
tb_nvram_models.sv
tb_nvram_backup.sv

//--- Makefile
# Verilator simulation of the NVRAM backup engine
TOP := tb_nvram_backup
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build output and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module $(TOP) -f filelist.f -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then echo "FAIL"; exit 1; fi
	@grep -q "Regression passed" $(LOG) || { echo "FAIL: run ended early"; exit 1; }
	@echo "PASS"

clean:
	rm -rf obj_dir $(LOG)
